// ==== vlog.f ====
+incdir+tb
hdl/rv_core_pkg.sv
hdl/rv_pipe_if.sv
hdl/rv_if_stage.sv
hdl/rv_register_file.sv
hdl/rv_id_stage.sv
hdl/rv_ex_stage.sv
hdl/rv_core.sv
tb/tb_clk_gen.sv
tb/tb_rv_core.sv

// ==== Makefile ====
# Verilator build and run of the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
SIM_LOG   ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(SIM_LOG)
	@grep -q "TEST PASSED" $(SIM_LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

// ==== tb/tb_rv_ref.svh ====
// Instruction-set model of the kept RV32I subset and program generator
// Expected stores are queued while the program is built

`ifndef TB_RV_REF_SVH
`define TB_RV_REF_SVH

// Plain RV32I integer semantics
function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'd0:    ref_alu = alt ? a - b : a + b;
    3'd1:    ref_alu = a << b[4:0];
    3'd2:    ref_alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3:    ref_alu = (a < b) ? 32'd1 : 32'd0;
    3'd4:    ref_alu = a ^ b;
    3'd5:    ref_alu = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6:    ref_alu = a | b;
    default: ref_alu = a & b;
  endcase
endfunction

// Applies one instruction to mregs, returns 1 for a store
function automatic bit ref_exec(input logic [31:0] instr, output logic [31:0] st_addr,
                                output logic [3:0] st_be, output logic [31:0] st_data);
  logic [4:0]  rd;
  logic [2:0]  f3;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] res;
  logic [1:0]  off;
  bit          wr;
  rd       = instr[11:7];
  f3       = instr[14:12];
  a        = mregs[instr[19:15]];
  b        = mregs[instr[24:20]];
  res      = '0;
  wr       = 1'b0;
  st_addr  = '0;
  st_be    = '0;
  st_data  = '0;
  ref_exec = 1'b0;
  case (instr[6:0])
    7'h33: begin
      res = ref_alu(f3, instr[30], a, b);
      wr  = 1'b1;
    end
    7'h13: begin
      // Only SRAI uses bit 30 among immediates
      res = ref_alu(f3, (f3 == 3'd5) && instr[30], a, {{20{instr[31]}}, instr[31:20]});
      wr  = 1'b1;
    end
    7'h37: begin
      res = {instr[31:12], 12'b0};
      wr  = 1'b1;
    end
    7'h23: begin
      st_addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
      off     = st_addr[1:0];
      case (f3[1:0])
        2'd0:    st_be = 4'b0001 << off;
        2'd1:    st_be = 4'b0011 << off;
        default: st_be = 4'b1111 << off;
      endcase
      st_data  = b << (8 * off);
      ref_exec = 1'b1;
    end
    default: ;
  endcase
  if (wr && (rd != 5'd0)) begin
    mregs[rd] = res;
  end
endfunction

// Places one instruction in memory and records its expected store
task automatic emit(input logic [31:0] instr, input int test_id);
  logic [31:0] addr;
  logic [3:0]  be;
  logic [31:0] data;
  imem[n_instr] = instr;
  n_instr++;
  if (ref_exec(instr, addr, be, data)) begin
    exp_addr.push_back(addr);
    exp_be.push_back(be);
    exp_data.push_back(data);
    exp_test.push_back(test_id);
    store_left[test_id]++;
  end
endtask

// Custom-0 opcode, unknown to the core
task automatic maybe_unknown(input int test_id);
  logic [31:0] r;
  logic [31:0] u;
  r = $urandom();
  if (r[2:0] == 3'd0) begin
    u = $urandom();
    emit({u[24:0], 7'h0B}, test_id);
  end
endtask

task automatic gen_program();
  logic [31:0] r;
  logic [31:0] s;
  logic [4:0]  rd;
  logic [2:0]  f3;
  logic        alt;
  logic [11:0] imm;
  for (int i = 0; i < 1024; i++) begin
    imem[i] = {i[24:0], 7'h0B};
  end
  // Random start values in x1..x31
  for (int i = 1; i < 32; i++) begin
    r = $urandom();
    emit({r[31:12], i[4:0], 7'h37}, 4);
    emit({r[11:0], i[4:0], 3'd0, i[4:0], 7'h13}, 4);
  end
  // Register-register ops, each checked by an aligned word store
  repeat (40) begin
    r   = $urandom();
    f3  = r[2:0];
    alt = r[3] && ((f3 == 3'd0) || (f3 == 3'd5));
    rd  = (r[6:4] == 3'd0) ? 5'd0 : r[11:7];
    emit({1'b0, alt, 5'b0, r[16:12], r[21:17], f3, rd, 7'h33}, 3);
    maybe_unknown(3);
    s = $urandom();
    emit({s[9:4], 1'b0, rd, 5'd0, 3'd2, s[2:0], 2'b00, 7'h23}, 3);
  end
  // Immediate ops and LUI
  repeat (30) begin
    r  = $urandom();
    s  = $urandom();
    f3 = r[2:0];
    rd = r[7:3];
    if (r[9:8] == 2'd0) begin
      emit({s[31:12], rd, 7'h37}, 4);
    end else begin
      if (f3 == 3'd1) begin
        imm = {7'b0, s[4:0]};
      end else if (f3 == 3'd5) begin
        imm = {1'b0, s[5], 5'b0, s[4:0]};
      end else begin
        imm = s[11:0];
      end
      emit({imm, r[14:10], f3, rd, 7'h13}, 4);
    end
    maybe_unknown(4);
    emit({s[21:16], 1'b0, rd, 5'd0, 3'd2, s[14:12], 2'b00, 7'h23}, 4);
  end
  // Byte and half stores at every offset
  for (int k = 0; k < 16; k++) begin
    r  = $urandom();
    s  = $urandom();
    rd = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
    emit({r[31:12], rd, 7'h37}, 5);
    emit({s[31:20], rd, 3'd0, rd, 7'h13}, 5);
    maybe_unknown(5);
    imm = {s[11:2], k[1:0]};
    emit({imm[11:5], rd, 5'd0, 1'b0, k[3:2] & 2'b01, imm[4:0], 7'h23}, 5);
  end
endtask

`endif

// ==== tb/tb_rv_core.sv ====
// Testbench for the RV32I core
// Random bus delays, stores compared in order against the ISA model

`timescale 1ns/1ns

module tb_rv_core;

  localparam logic [31:0] BOOT = 32'h0000_1000;

  logic        clk;
  logic        rst_n;
  logic        fetch_enable_i;
  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  logic [31:0] instr_rdata_i;
  logic        data_req_o;
  logic [31:0] data_addr_o;
  logic [3:0]  data_be_o;
  logic [31:0] data_wdata_o;
  logic        data_gnt_i;

  // Program image, model state and expected stores
  logic [31:0] imem [1024];
  logic [31:0] mregs [32];
  logic [31:0] exp_addr [$];
  logic [3:0]  exp_be [$];
  logic [31:0] exp_data [$];
  int          exp_test [$];
  int          store_left [1:6];
  int          test_err [1:6];
  string       test_name [1:6];
  int          n_instr;
  int          fetch_cnt;
  int          cycles;
  int          limit;
  int          n_pass;
  int          n_fail;
  int          total_err;
  int unsigned seed_val;
  logic [1:0]  igc;
  logic [1:0]  rvc;
  logic [1:0]  dgc;
  logic        pend;
  logic [31:0] pend_addr;

  `include "tb_rv_ref.svh"

  tb_clk_gen #(.PERIOD(8), .RST_CYCLES(10)) clk_gen_i (.clk_o(clk), .rst_n_o(rst_n));

  rv_core #(.RV32(rv_core_pkg::RV32I)) DUT (
    .clk_i(clk), .rst_n_i(rst_n), .fetch_enable_i(fetch_enable_i), .boot_addr_i(BOOT),
    .instr_req_o(instr_req_o), .instr_addr_o(instr_addr_o), .instr_gnt_i(instr_gnt_i),
    .instr_rvalid_i(instr_rvalid_i), .instr_rdata_i(instr_rdata_i),
    .data_req_o(data_req_o), .data_addr_o(data_addr_o), .data_be_o(data_be_o),
    .data_wdata_o(data_wdata_o), .data_gnt_i(data_gnt_i)
  );

  task automatic check(input int test_id, input string name, input logic [31:0] got,
                       input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      test_err[test_id]++;
    end
  endtask

  task automatic report_test(input int id);
    $display("Test %0d %s: %s (%0d errors)", id, test_name[id],
             (test_err[id] == 0) ? "ok" : "failed", test_err[id]);
  endtask

  // Past the image, the word folds in all index bits
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - BOOT) >> 2;
    fetch_word = (idx < 1024) ? imem[idx[9:0]] :
                 {idx[24:0] ^ {18'b0, idx[31:25]}, 7'h0B};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Bus models
  ////////////////////////////////////////////////////////////////////////////

  // Instruction bus, grant and rvalid after 0 to 3 cycles
  always @(posedge clk) begin
    if (!rst_n) begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      pend           <= 1'b0;
      igc            <= 2'($urandom());
    end else begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      if (instr_req_o && instr_gnt_i) begin
        check((fetch_cnt == 0) ? 1 : 2, "instr_addr_o", instr_addr_o, BOOT + 32'(4 * fetch_cnt));
        fetch_cnt <= fetch_cnt + 1;
        pend      <= 1'b1;
        pend_addr <= instr_addr_o;
        rvc       <= 2'($urandom());
        igc       <= 2'($urandom());
      end else if (instr_req_o) begin
        if (igc == 2'd0) instr_gnt_i <= 1'b1;
        else igc <= igc - 2'd1;
      end
      if (pend) begin
        if (rvc == 2'd0) begin
          instr_rvalid_i <= 1'b1;
          instr_rdata_i  <= fetch_word(pend_addr);
          pend           <= 1'b0;
        end else begin
          rvc <= rvc - 2'd1;
        end
      end
    end
  end

  // Data bus grant
  always @(posedge clk) begin
    if (!rst_n) begin
      data_gnt_i <= 1'b0;
      dgc        <= 2'($urandom());
    end else begin
      data_gnt_i <= 1'b0;
      if (data_req_o && data_gnt_i) begin
        dgc <= 2'($urandom());
      end else if (data_req_o) begin
        if (dgc == 2'd0) data_gnt_i <= 1'b1;
        else dgc <= dgc - 2'd1;
      end
    end
  end

  // Each granted store against the head of the expected queue
  always @(posedge clk) begin
    int t;
    if (rst_n && data_req_o && data_gnt_i) begin
      if (exp_addr.size() == 0) begin
        $display("Unexpected store at %0t ns to address %h", $time, data_addr_o);
        test_err[6]++;
      end else begin
        t = exp_test.pop_front();
        check(t, "data_addr_o", data_addr_o, exp_addr.pop_front());
        check(t, "data_be_o", 32'(data_be_o), 32'(exp_be.pop_front()));
        check(t, "data_wdata_o", data_wdata_o, exp_data.pop_front());
        store_left[t]--;
        if (store_left[t] == 0) report_test(t);
      end
    end
  end

  // Timeout
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("Timeout after %0d cycles, %0d stores never seen", cycles, exp_addr.size());
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed_val       = $urandom(23);
    fetch_enable_i = 1'b0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    data_gnt_i     = 1'b0;
    n_instr        = 0;
    fetch_cnt      = 0;
    cycles         = 0;
    test_name      = '{"fetch enable and boot", "sequential fetch", "reg-reg ALU",
                       "immediate ALU and LUI", "byte and half stores", "delays and unknown ops"};
    for (int i = 1; i <= 6; i++) begin
      store_left[i] = 0;
      test_err[i]   = 0;
    end
    for (int i = 0; i < 32; i++) mregs[i] = '0;
    gen_program();
    limit = n_instr * 12 + 200;
    @(posedge rst_n);
    // Fetch held off
    repeat (20) begin
      @(posedge clk);
      check(1, "instr_req_o", 32'(instr_req_o), 32'd0);
      check(1, "data_req_o", 32'(data_req_o), 32'd0);
    end
    fetch_enable_i <= 1'b1;
    while (fetch_cnt == 0) @(posedge clk);
    report_test(1);
    while (exp_addr.size() != 0) @(posedge clk);
    // Trailing unknown words must not store
    repeat (40) @(posedge clk);
    report_test(2);
    report_test(6);
    n_pass    = 0;
    n_fail    = 0;
    total_err = 0;
    for (int i = 1; i <= 6; i++) begin
      total_err += test_err[i];
      if (test_err[i] == 0) n_pass++;
      else n_fail++;
    end
    $display("Tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, total_err);
    if (total_err == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/tb_clk_gen.sv ====
// Testbench clock and reset source
// Free running clock, reset held low for a fixed number of cycles

`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD     = 8,
  parameter int RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== hdl/rv_core.sv ====
// RV32I integer core top level
// Fetch, decode and execute with write-back, plain bus ports

`timescale 1ns/1ns

module rv_core #(
  parameter rv_core_pkg::rv32_e RV32 = rv_core_pkg::RV32I
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            fetch_enable_i,
  input  logic [rv_core_pkg::XLEN-1:0]    boot_addr_i,

  // Instruction bus
  output logic                            instr_req_o,
  output logic [rv_core_pkg::XLEN-1:0]    instr_addr_o,
  input  logic                            instr_gnt_i,
  input  logic                            instr_rvalid_i,
  input  logic [rv_core_pkg::INSTR_W-1:0] instr_rdata_i,

  // Data bus
  output logic                            data_req_o,
  output logic [rv_core_pkg::XLEN-1:0]    data_addr_o,
  output logic [rv_core_pkg::BE_W-1:0]    data_be_o,
  output logic [rv_core_pkg::XLEN-1:0]    data_wdata_o,
  input  logic                            data_gnt_i
);

  // Write-back from EX to register file and forwarding
  logic                               wb_we;
  logic [rv_core_pkg::REG_ADDR_W-1:0] wb_addr;
  logic [rv_core_pkg::XLEN-1:0]       wb_data;

  if_id_if if_id_link ();
  id_ex_if id_ex_link ();

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline stages
  ////////////////////////////////////////////////////////////////////////////

  rv_if_stage if_stage_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .if_id          ( if_id_link     )
  );

  rv_id_stage #(
    .RV32      ( RV32       )
  ) id_stage_i (
    .clk_i     ( clk_i      ),
    .rst_n_i   ( rst_n_i    ),
    .if_id     ( if_id_link ),
    .id_ex     ( id_ex_link ),
    .wb_we_i   ( wb_we      ),
    .wb_addr_i ( wb_addr    ),
    .wb_data_i ( wb_data    )
  );

  rv_ex_stage ex_stage_i (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .id_ex        ( id_ex_link   ),
    .data_req_o   ( data_req_o   ),
    .data_addr_o  ( data_addr_o  ),
    .data_be_o    ( data_be_o    ),
    .data_wdata_o ( data_wdata_o ),
    .data_gnt_i   ( data_gnt_i   ),
    .wb_we_o      ( wb_we        ),
    .wb_addr_o    ( wb_addr      ),
    .wb_data_o    ( wb_data      )
  );

endmodule

// ==== hdl/rv_ex_stage.sv ====
// Execute stage with ALU, store issue and register write-back
// A store sits on the data bus until its grant arrives

`timescale 1ns/1ns

module rv_ex_stage (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  id_ex_if.execute                           id_ex,

  // Data bus, stores only
  output logic                               data_req_o,
  output logic [rv_core_pkg::XLEN-1:0]       data_addr_o,
  output logic [rv_core_pkg::BE_W-1:0]       data_be_o,
  output logic [rv_core_pkg::XLEN-1:0]       data_wdata_o,
  input  logic                               data_gnt_i,

  // Register write-back
  output logic                               wb_we_o,
  output logic [rv_core_pkg::REG_ADDR_W-1:0] wb_addr_o,
  output logic [rv_core_pkg::XLEN-1:0]       wb_data_o
);

  logic [rv_core_pkg::XLEN-1:0] alu_res;
  logic                         st_req;
  logic [rv_core_pkg::BE_W-1:0] be_base;
  logic [rv_core_pkg::BE_W-1:0] st_be;
  logic [rv_core_pkg::XLEN-1:0] st_wdata;

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (id_ex.alu_op)
      rv_core_pkg::ALU_SUB:  alu_res = id_ex.op_a - id_ex.op_b;
      rv_core_pkg::ALU_SLL:  alu_res = id_ex.op_a << id_ex.op_b[4:0];
      rv_core_pkg::ALU_SLT:  alu_res = {31'b0, $signed(id_ex.op_a) < $signed(id_ex.op_b)};
      rv_core_pkg::ALU_SLTU: alu_res = {31'b0, id_ex.op_a < id_ex.op_b};
      rv_core_pkg::ALU_XOR:  alu_res = id_ex.op_a ^ id_ex.op_b;
      rv_core_pkg::ALU_SRL:  alu_res = id_ex.op_a >> id_ex.op_b[4:0];
      rv_core_pkg::ALU_SRA:  alu_res = $unsigned($signed(id_ex.op_a) >>> id_ex.op_b[4:0]);
      rv_core_pkg::ALU_OR:   alu_res = id_ex.op_a | id_ex.op_b;
      rv_core_pkg::ALU_AND:  alu_res = id_ex.op_a & id_ex.op_b;
      default:               alu_res = id_ex.op_a + id_ex.op_b;
    endcase
  end

  // ALU ops finish at once, stores wait for grant
  assign st_req      = id_ex.valid && id_ex.is_store;
  assign id_ex.ready = !(st_req && !data_gnt_i);

  assign wb_we_o   = id_ex.valid && id_ex.rd_we;
  assign wb_addr_o = id_ex.rd;
  assign wb_data_o = alu_res;

  ////////////////////////////////////////////////////////////////////////////
  // Store lanes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (id_ex.store_size)
      rv_core_pkg::ST_BYTE: be_base = 4'b0001;
      rv_core_pkg::ST_HALF: be_base = 4'b0011;
      default:              be_base = 4'b1111;
    endcase
  end

  // Shift enables and data up by the byte offset
  assign st_be    = be_base << alu_res[1:0];
  assign st_wdata = id_ex.store_data << {alu_res[1:0], 3'b000};

  // ID/EX keeps the store until grant, so the bus follows it directly
  assign data_req_o   = st_req;
  assign data_addr_o  = alu_res;
  assign data_be_o    = st_be;
  assign data_wdata_o = st_wdata;

endmodule

// ==== hdl/rv_id_stage.sv ====
// Decode stage with register file read and operand forwarding
// Builds ALU control and operands and loads the ID/EX register

`timescale 1ns/1ns

module rv_id_stage #(
  parameter rv_core_pkg::rv32_e RV32 = rv_core_pkg::RV32I
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  if_id_if.decode                            if_id,
  id_ex_if.decode                            id_ex,

  // Write-back from EX, also used for forwarding
  input  logic                               wb_we_i,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] wb_addr_i,
  input  logic [rv_core_pkg::XLEN-1:0]       wb_data_i
);

  rv_core_pkg::opcode_e               opcode;
  logic [2:0]                         funct3;
  logic [rv_core_pkg::REG_ADDR_W-1:0] rs1;
  logic [rv_core_pkg::REG_ADDR_W-1:0] rs2;
  logic [rv_core_pkg::XLEN-1:0]       rf_rdata_a;
  logic [rv_core_pkg::XLEN-1:0]       rf_rdata_b;
  logic [rv_core_pkg::XLEN-1:0]       rs1_val;
  logic [rv_core_pkg::XLEN-1:0]       rs2_val;
  logic [rv_core_pkg::XLEN-1:0]       imm_i;
  logic [rv_core_pkg::XLEN-1:0]       imm_s;
  logic [rv_core_pkg::XLEN-1:0]       imm_u;
  rv_core_pkg::alu_op_e               alu_op;
  logic [rv_core_pkg::XLEN-1:0]       op_a;
  logic [rv_core_pkg::XLEN-1:0]       op_b;
  logic                               rd_we;
  logic                               is_store;
  rv_core_pkg::store_size_e           st_size;
  logic                               accept;

  // funct3 to ALU op, bit 30 picks SUB (reg only) and SRA
  function automatic rv_core_pkg::alu_op_e dec_alu(input logic [2:0] f3,
                                                   input logic       f7_5,
                                                   input logic       is_reg);
    case (f3)
      3'b000:  dec_alu = (is_reg && f7_5) ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
      3'b001:  dec_alu = rv_core_pkg::ALU_SLL;
      3'b010:  dec_alu = rv_core_pkg::ALU_SLT;
      3'b011:  dec_alu = rv_core_pkg::ALU_SLTU;
      3'b100:  dec_alu = rv_core_pkg::ALU_XOR;
      3'b101:  dec_alu = f7_5 ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
      3'b110:  dec_alu = rv_core_pkg::ALU_OR;
      default: dec_alu = rv_core_pkg::ALU_AND;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Register read and forwarding
  ////////////////////////////////////////////////////////////////////////////

  assign opcode = rv_core_pkg::opcode_e'(if_id.instr[6:0]);
  assign funct3 = if_id.instr[14:12];
  assign rs1    = if_id.instr[19:15];
  assign rs2    = if_id.instr[24:20];

  rv_register_file #(
    .RV32      ( RV32       )
  ) register_file_i (
    .clk_i     ( clk_i      ),
    .rst_n_i   ( rst_n_i    ),
    .raddr_a_i ( rs1        ),
    .raddr_b_i ( rs2        ),
    .rdata_a_o ( rf_rdata_a ),
    .rdata_b_o ( rf_rdata_b ),
    .we_i      ( wb_we_i    ),
    .waddr_i   ( wb_addr_i  ),
    .wdata_i   ( wb_data_i  )
  );

  // Same-cycle EX write wins over the array, never for x0
  assign rs1_val = (wb_we_i && (wb_addr_i == rs1) && (rs1 != '0)) ? wb_data_i : rf_rdata_a;
  assign rs2_val = (wb_we_i && (wb_addr_i == rs2) && (rs2 != '0)) ? wb_data_i : rf_rdata_b;

  // Immediates
  assign imm_i = {{20{if_id.instr[31]}}, if_id.instr[31:20]};
  assign imm_s = {{20{if_id.instr[31]}}, if_id.instr[31:25], if_id.instr[11:7]};
  assign imm_u = {if_id.instr[31:12], 12'b0};

  ////////////////////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Unknown opcodes fall through as no-op
    alu_op   = rv_core_pkg::ALU_ADD;
    op_a     = rs1_val;
    op_b     = rs2_val;
    rd_we    = 1'b0;
    is_store = 1'b0;
    st_size  = rv_core_pkg::ST_WORD;
    case (opcode)
      rv_core_pkg::OPC_OP: begin
        alu_op = dec_alu(funct3, if_id.instr[30], 1'b1);
        rd_we  = 1'b1;
      end
      rv_core_pkg::OPC_OP_IMM: begin
        alu_op = dec_alu(funct3, if_id.instr[30], 1'b0);
        op_b   = imm_i;
        rd_we  = 1'b1;
      end
      // LUI is zero plus the upper immediate
      rv_core_pkg::OPC_LUI: begin
        op_a  = '0;
        op_b  = imm_u;
        rd_we = 1'b1;
      end
      // Address is rs1 plus offset
      rv_core_pkg::OPC_STORE: begin
        op_b     = imm_s;
        is_store = 1'b1;
        case (funct3[1:0])
          2'b00:   st_size = rv_core_pkg::ST_BYTE;
          2'b01:   st_size = rv_core_pkg::ST_HALF;
          default: st_size = rv_core_pkg::ST_WORD;
        endcase
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // ID/EX pipeline register
  ////////////////////////////////////////////////////////////////////////////

  // Stall only when ID/EX is full and EX holds it
  assign if_id.ready = !id_ex.valid || id_ex.ready;
  assign accept      = if_id.valid && if_id.ready;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_ex.valid <= 1'b0;
    end else if (accept) begin
      id_ex.valid <= 1'b1;
    end else if (id_ex.ready) begin
      id_ex.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_ex.alu_op     <= alu_op;
      id_ex.op_a       <= op_a;
      id_ex.op_b       <= op_b;
      id_ex.rd         <= if_id.instr[11:7];
      id_ex.rd_we      <= rd_we;
      id_ex.is_store   <= is_store;
      id_ex.store_size <= st_size;
      id_ex.store_data <= rs2_val;
    end
  end

endmodule

// ==== hdl/rv_register_file.sv ====
// Integer register file, two read ports and one write port
// 32 entries for RV32I, 16 for RV32E; x0 is hard zero

`timescale 1ns/1ns

module rv_register_file #(
  parameter rv_core_pkg::rv32_e RV32 = rv_core_pkg::RV32I
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [rv_core_pkg::XLEN-1:0]       rdata_a_o,
  output logic [rv_core_pkg::XLEN-1:0]       rdata_b_o,
  input  logic                               we_i,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [rv_core_pkg::XLEN-1:0]       wdata_i
);

  // RV32E drops the top index bit
  localparam int AW       = (RV32 == rv_core_pkg::RV32E) ? 4 : 5;
  localparam int NUM_REGS = 2 ** AW;

  logic [rv_core_pkg::XLEN-1:0] regs_q [NUM_REGS];

  // Entry 0 is never written
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      regs_q <= '{default: '0};
    end else if (we_i && (waddr_i[AW-1:0] != '0)) begin
      regs_q[waddr_i[AW-1:0]] <= wdata_i;
    end
  end

  assign rdata_a_o = regs_q[raddr_a_i[AW-1:0]];
  assign rdata_b_o = regs_q[raddr_b_i[AW-1:0]];

endmodule

// ==== hdl/rv_if_stage.sv ====
// Instruction fetch stage
// Sequential fetch over the req/gnt/rvalid instruction bus
// into a one-entry buffer that feeds decode

`timescale 1ns/1ns

module rv_if_stage (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            fetch_enable_i,
  input  logic [rv_core_pkg::XLEN-1:0]    boot_addr_i,

  // Instruction bus
  output logic                            instr_req_o,
  output logic [rv_core_pkg::XLEN-1:0]    instr_addr_o,
  input  logic                            instr_gnt_i,
  input  logic                            instr_rvalid_i,
  input  logic [rv_core_pkg::INSTR_W-1:0] instr_rdata_i,

  if_id_if.fetch                          if_id
);

  typedef enum logic {
    IDLE,
    WAIT_RVALID
  } fetch_state_e;

  fetch_state_e                    state_q;
  logic                            boot_q;
  logic                            hold_q;
  logic                            buf_valid_q;
  logic [rv_core_pkg::XLEN-1:0]    pc_q;
  logic [rv_core_pkg::XLEN-1:0]    buf_pc_q;
  logic [rv_core_pkg::INSTR_W-1:0] buf_instr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Bus request
  ////////////////////////////////////////////////////////////////////////////

  // First fetch after reset comes from the boot address
  assign instr_addr_o = boot_q ? boot_addr_i : pc_q;

  // New request only with free buffer, an ungranted one stays up
  assign instr_req_o = (state_q == IDLE) &&
                       (hold_q || (fetch_enable_i && !buf_valid_q));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      boot_q      <= 1'b1;
      hold_q      <= 1'b0;
      buf_valid_q <= 1'b0;
      pc_q        <= '0;
    end else begin
      hold_q <= instr_req_o && !instr_gnt_i;
      // Granted, next address is the following word
      if (instr_req_o && instr_gnt_i) begin
        state_q <= WAIT_RVALID;
        boot_q  <= 1'b0;
        pc_q    <= instr_addr_o + rv_core_pkg::XLEN'(4);
      end
      // Response fills the buffer, decode drains it
      if ((state_q == WAIT_RVALID) && instr_rvalid_i) begin
        state_q     <= IDLE;
        buf_valid_q <= 1'b1;
      end else if (if_id.valid && if_id.ready) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

  // Buffer payload, pc captured at grant
  always_ff @(posedge clk_i) begin
    if (instr_req_o && instr_gnt_i) begin
      buf_pc_q <= instr_addr_o;
    end
    if ((state_q == WAIT_RVALID) && instr_rvalid_i) begin
      buf_instr_q <= instr_rdata_i;
    end
  end

  assign if_id.valid = buf_valid_q;
  assign if_id.instr = buf_instr_q;
  assign if_id.pc    = buf_pc_q;

endmodule

// ==== hdl/rv_pipe_if.sv ====
// Stage to stage links of the core pipeline
// Each link carries a valid/ready pair and the stage payload

`timescale 1ns/1ns

// IF to ID link
interface if_id_if;

  logic                            valid;
  logic                            ready;
  logic [rv_core_pkg::INSTR_W-1:0] instr;
  logic [rv_core_pkg::XLEN-1:0]    pc;

  modport fetch (output valid, output instr, output pc, input ready);
  modport decode (input valid, input instr, input pc, output ready);

endinterface

// ID to EX link
interface id_ex_if;

  logic                               valid;
  logic                               ready;
  rv_core_pkg::alu_op_e               alu_op;
  logic [rv_core_pkg::XLEN-1:0]       op_a;
  logic [rv_core_pkg::XLEN-1:0]       op_b;
  logic [rv_core_pkg::REG_ADDR_W-1:0] rd;
  logic                               rd_we;
  logic                               is_store;
  rv_core_pkg::store_size_e           store_size;
  logic [rv_core_pkg::XLEN-1:0]       store_data;

  // Decode drives the payload, execute answers with ready
  modport decode (
    output valid, output alu_op, output op_a, output op_b, output rd, output rd_we,
    output is_store, output store_size, output store_data, input ready
  );
  modport execute (
    input valid, input alu_op, input op_a, input op_b, input rd, input rd_we,
    input is_store, input store_size, input store_data, output ready
  );

endinterface

// ==== hdl/rv_core_pkg.sv ====
// Shared widths and types of the RV32I integer core
// Opcode, ALU and store size encodings used by decode and execute

package rv_core_pkg;

  // Datapath widths
  parameter int XLEN       = 32;
  parameter int INSTR_W    = 32;
  parameter int REG_ADDR_W = 5;
  parameter int BE_W       = 4;

  // Register file variant
  typedef enum logic {
    RV32I,
    RV32E
  } rv32_e;

  // Major opcodes handled by the core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_STORE  = 7'b0100011
  } opcode_e;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // Store access size, same order as funct3[1:0]
  typedef enum logic [1:0] {
    ST_BYTE,
    ST_HALF,
    ST_WORD
  } store_size_e;

endpackage
